/* bench/rmii_bridge_tb_tasks.svh */
`ifndef RMII_BRIDGE_TB_TASKS_SVH
`define RMII_BRIDGE_TB_TASKS_SVH

task automatic check_tx_word(input string name, input eth_tx_bus_t exp, input eth_tx_bus_t act);
	if (act !== exp) begin
		$display("error %s: expected bytes %0d data %h commit %b, actual bytes %0d data %h commit %b",
			name, exp.bytes_valid, exp.data, exp.commit, act.bytes_valid, act.data, act.commit);
		test_errs++;
	end
endtask

task automatic check_dibit(input string name, input int idx, input logic [1:0] exp,
	input logic [1:0] act);
	if (act !== exp) begin
		$display("error %s: dibit %0d expected %b actual %b", name, idx, exp, act);
		test_errs++;
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		$display("error %s: expected %0d actual %0d", name, exp, act);
		test_errs++;
	end
endtask

// Drives one host frame; a stop_words of zero or more aborts it with drop at that word
task automatic send_frame(input int len, input int stop_words);
	int nwords;
	int w;
	int b;
	int nb;
	logic [31:0] word;
	nwords = (len + 3) / 4;
	next_edge();
	host_rx_start = 1'b1;
	next_edge();
	host_rx_start = 1'b0;
	for (w = 0; w < nwords; w++) begin
		if (stop_words >= 0 && w == stop_words) begin
			host_rx_drop = 1'b1;	// Abort replaces the next word
			next_edge();
			host_rx_drop = 1'b0;
			return;
		end
		nb = (len - 4 * w > 4) ? 4 : len - 4 * w;
		word = '0;
		for (b = 0; b < nb; b++) begin
			word[8 * b +: 8] = frame_bytes[4 * w + b];	// Byte 0 sits in the low lane
		end
		host_rx_data_valid = 1'b1;
		host_rx_bytes_valid = 3'(nb);
		host_rx_data = word;
		next_edge();
		host_rx_data_valid = 1'b0;
		repeat (`MIN_WORD_SPACING - 1) next_edge();	// Host pacing rule
	end
	host_rx_commit = 1'b1;
	next_edge();
	host_rx_commit = 1'b0;
endtask

// Compares the words collected since base with the frame bytes
task automatic check_frame(input string name, input int base, input int len, input int count);
	eth_tx_bus_t exp;
	int total;
	int w;
	int b;
	int nb;
	total = (len + 3) / 4;
	check_count({name, " word count"}, count, word_q.size() - base);
	for (w = 0; w < count && base + w < word_q.size(); w++) begin
		nb = (len - 4 * w > 4) ? 4 : len - 4 * w;
		exp = '0;
		exp.data_valid = 1'b1;
		exp.bytes_valid = 3'(nb);
		for (b = 0; b < nb; b++) begin
			exp.data[8 * b +: 8] = frame_bytes[4 * w + b];	// Unused lanes stay zero
		end
		exp.commit = (w == total - 1);	// Only the real final word closes the frame
		check_tx_word(name, exp, word_q[base + w]);
	end
endtask

`endif

/* bench/rmii_bridge_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ethernet_bus_consts.svh"

module rmii_bridge_tb
	import ethernet_bus_pkg::*;
();

	localparam int NUM_TESTS = 8;
	localparam int MODE_LOOP = 0;	// RMII receive pins wired back to transmit
	localparam int MODE_DIRECT = 1;	// Transmit pins driven by the testbench
	localparam int MODE_DROP = 2;	// Aborted frame, also wired back to transmit

	typedef struct {
		string name;
		int len;	// Frame bytes, or preamble bytes of noise
		int ready_low;	// Cycles of host_tx_ready low, negative holds it low
		int mode;
	} test_row_t;

	test_row_t tests [NUM_TESTS] = '{
		'{"framing_direct", 8, 0, MODE_DIRECT},
		'{"loop_len1", 1, 0, MODE_LOOP},
		'{"loop_len4", 4, 0, MODE_LOOP},
		'{"loop_len7", 7, 0, MODE_LOOP},
		'{"loop_len64", 64, 0, MODE_LOOP},
		'{"backpressure", 20, 80, MODE_LOOP},
		'{"overflow", 64, -1, MODE_LOOP},
		'{"drop", 16, 0, MODE_DROP}
	};

	logic clk_50mhz = 1'b0;
	logic rst_n;
	logic host_rx_start;
	logic host_rx_data_valid;
	logic [2:0] host_rx_bytes_valid;
	logic [31:0] host_rx_data;
	logic host_rx_commit;
	logic host_rx_drop;
	logic host_tx_ready;
	logic host_tx_start;
	logic host_tx_data_valid;
	logic [2:0] host_tx_bytes_valid;
	logic [31:0] host_tx_data;
	logic host_tx_commit;
	logic host_tx_overflow;
	logic rmii_refclk;
	logic rmii_rx_en;
	logic [1:0] rmii_rxd;
	logic rmii_tx_en;
	logic [1:0] rmii_txd;
	logic loop_sel;
	logic drv_tx_en;
	logic [1:0] drv_txd;
	integer seed = 32'h728a_5718;
	logic [7:0] frame_bytes [64];
	logic [1:0] dibit_q [$];	// Receive dibits seen while rx_en is high
	eth_tx_bus_t word_q [$];	// Host transmit words in arrival order
	int start_cnt = 0;
	int ovf_cnt = 0;
	int commit_cnt = 0;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	int test_errs;
	int pass_cnt = 0;
	int fail_cnt = 0;

	// Loopback or testbench-driven dibits into the decoder
	assign rmii_tx_en = loop_sel ? rmii_rx_en : drv_tx_en;
	assign rmii_txd = loop_sel ? rmii_rxd : drv_txd;

	rmii_bridge_top dut_i (
		.clk_50mhz(clk_50mhz),
		.rst_n(rst_n),
		.host_rx_start(host_rx_start),
		.host_rx_data_valid(host_rx_data_valid),
		.host_rx_bytes_valid(host_rx_bytes_valid),
		.host_rx_data(host_rx_data),
		.host_rx_commit(host_rx_commit),
		.host_rx_drop(host_rx_drop),
		.host_tx_ready(host_tx_ready),
		.host_tx_start(host_tx_start),
		.host_tx_data_valid(host_tx_data_valid),
		.host_tx_bytes_valid(host_tx_bytes_valid),
		.host_tx_data(host_tx_data),
		.host_tx_commit(host_tx_commit),
		.host_tx_overflow(host_tx_overflow),
		.rmii_refclk(rmii_refclk),
		.rmii_rx_en(rmii_rx_en),
		.rmii_rxd(rmii_rxd),
		.rmii_tx_en(rmii_tx_en),
		.rmii_txd(rmii_txd)
	);

	always #10 clk_50mhz = ~clk_50mhz;	// 50 MHz

	// Inputs change a little after the rising edge
	task automatic next_edge();
		@(posedge clk_50mhz);
		#2;
	endtask

	`include "rmii_bridge_tb_tasks.svh"

	// Outputs are sampled on the falling edge where they are settled
	always @(negedge clk_50mhz) begin
		if (rst_n) begin
			if (rmii_rx_en) dibit_q.push_back(rmii_rxd);
			if (host_tx_start) start_cnt++;
			if (host_tx_overflow) ovf_cnt++;
			if (host_tx_data_valid && host_tx_commit) commit_cnt++;
			if (host_tx_data_valid) begin
				word_q.push_back('{start: 1'b0, data_valid: 1'b1, bytes_valid: host_tx_bytes_valid,
					data: host_tx_data, commit: host_tx_commit});
			end
		end
	end

	always @(posedge clk_50mhz) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic report_test(input string name);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("test %s passed", name);
		end else begin
			fail_cnt++;
			$display("test %s failed with %0d errors", name, test_errs);
		end
	endtask

	// Preamble, delimiter and frame bytes dibit by dibit, a dropped frame stops short
	task automatic check_rx_dibits(input string name, input int base, input int len,
		input logic dropped);
		int n;
		int full;
		int i;
		logic [1:0] exp;
		n = dibit_q.size() - base;
		full = 32 + 4 * len;
		if (!dropped) begin
			check_count({name, " rx_en dibits"}, full, n);
		end else if (n >= full) begin
			$display("error %s: drop did not cut rx_en short, %0d dibits sent", name, n);
			test_errs++;
		end
		for (i = 0; i < n && i < full; i++) begin
			if (i < 31) exp = 2'b01;
			else if (i == 31) exp = 2'b11;
			else exp = frame_bytes[(i - 32) / 4][((i - 32) % 4) * 2 +: 2];
			check_dibit(name, i, exp, dibit_q[base + i]);
		end
	endtask

	task automatic run_test(input int idx);
		test_row_t row;
		int words;
		int dbase;
		int wbase;
		int sbase;
		int obase;
		int cbase;
		int i;
		row = tests[idx];
		words = (row.len + 3) / 4;
		test_errs = 0;
		for (i = 0; i < row.len; i++) begin
			frame_bytes[i] = 8'($random(seed));
		end
		loop_sel = (row.mode == MODE_LOOP || row.mode == MODE_DROP);
		host_tx_ready = (row.ready_low == 0);
		dbase = dibit_q.size();
		wbase = word_q.size();
		sbase = start_cnt;
		obase = ovf_cnt;
		cbase = commit_cnt;
		fork
			send_frame(row.len, (row.mode == MODE_DROP) ? 2 : -1);
			begin
				if (row.ready_low > 0) begin
					repeat (row.ready_low) next_edge();
					host_tx_ready = 1'b1;	// Host catches up after its stall
				end
			end
		join
		while (dibit_q.size() == dbase || rmii_rx_en) next_edge();
		check_rx_dibits(row.name, dbase, row.len, row.mode == MODE_DROP);
		if (row.mode == MODE_LOOP && row.ready_low >= 0) begin
			while (commit_cnt == cbase) next_edge();
			check_frame(row.name, wbase, row.len, words);
			check_count({row.name, " starts"}, 1, start_cnt - sbase);
			check_count({row.name, " overflows"}, 0, ovf_cnt - obase);
		end else if (row.mode == MODE_LOOP) begin
			repeat (16) next_edge();	// Decoder end marker reaches the packer
			host_tx_ready = 1'b1;
			repeat (16) next_edge();
			check_frame(row.name, wbase, row.len, `WORD_FIFO_DEPTH);
			check_count({row.name, " overflows"}, words - `WORD_FIFO_DEPTH, ovf_cnt - obase);
		end else if (row.mode == MODE_DROP) begin
			repeat (16) next_edge();
			check_count({row.name, " commits"}, 0, commit_cnt - cbase);
		end
		report_test(row.name);
	endtask

	// Preamble dibits with carrier but never a delimiter
	task automatic run_noise(input int nbytes);
		int sbase;
		int wbase;
		test_errs = 0;
		sbase = start_cnt;
		wbase = word_q.size();
		loop_sel = 1'b0;
		host_tx_ready = 1'b1;
		next_edge();
		drv_tx_en = 1'b1;
		drv_txd = 2'b01;
		repeat (4 * nbytes) next_edge();
		drv_txd = 2'b00;
		repeat (8) next_edge();
		drv_tx_en = 1'b0;
		repeat (40) next_edge();
		check_count("noise starts", 0, start_cnt - sbase);
		check_count("noise words", 0, word_q.size() - wbase);
		report_test("noise");
	endtask

	initial begin
		int t;
		int total;
		total = 64 + 16 * 10 + 80 * 3;	// Noise test budget
		for (t = 0; t < NUM_TESTS; t++) begin
			total += 64 + 16 * tests[t].len + 80 * ((tests[t].len + 3) / 4);
		end
		cycle_limit = total * 3 / 2;
		rst_n = 1'b0;
		host_rx_start = 1'b0;
		host_rx_data_valid = 1'b0;
		host_rx_bytes_valid = 3'd0;
		host_rx_data = 32'd0;
		host_rx_commit = 1'b0;
		host_rx_drop = 1'b0;
		host_tx_ready = 1'b1;
		loop_sel = 1'b0;
		drv_tx_en = 1'b0;
		drv_txd = 2'b00;
		repeat (4) next_edge();
		test_errs = 0;	// Control outputs while still in reset
		check_count("reset rmii_rx_en", 0, int'(rmii_rx_en));
		check_count("reset host_tx_start", 0, int'(host_tx_start));
		check_count("reset host_tx_data_valid", 0, int'(host_tx_data_valid));
		check_count("reset host_tx_commit", 0, int'(host_tx_commit));
		check_count("reset host_tx_overflow", 0, int'(host_tx_overflow));
		report_test("reset_values");
		rst_n = 1'b1;
		repeat (4) next_edge();
		test_errs = 0;	// Reference clock is the inverse of the system clock
		check_count("refclk with clock high", 0, int'(rmii_refclk));
		@(negedge clk_50mhz);
		#2;
		check_count("refclk with clock low", 1, int'(rmii_refclk));
		report_test("refclk");
		next_edge();
		for (t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
			repeat (20) next_edge();	// Idle gap between frames
		end
		run_noise(10);
		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rmii_bridge_top.f */
+incdir+src
+incdir+bench
src/ethernet_bus_pkg.sv
src/byte_lane_if.sv
src/rmii_dibit_decoder.sv
src/byte_word_packer.sv
src/rmii_frame_transmitter.sv
src/rmii_bridge_top.sv
bench/rmii_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the bridge testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rmii_bridge_tb \
	-f rmii_bridge_top.f -o rmii_bridge_sim > build.log 2>&1 \
	&& ./obj_dir/rmii_bridge_sim > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation reported failures, see sim.log"; exit 1; }

/* src/byte_lane_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One decoded frame byte per strobe plus frame boundary markers
interface byte_lane_if;

	logic valid;	// One-cycle byte strobe
	logic [7:0] data;	// Byte value, meaningful with valid
	logic first;	// Marks the first data byte of a frame
	logic last;	// One-cycle end of frame, with or after the final byte

	modport src (
		output valid,
		output data,
		output first,
		output last
	);

	modport dst (
		input valid,
		input data,
		input first,
		input last
	);

endinterface

`default_nettype wire

/* src/byte_word_packer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ethernet_bus_consts.svh"

module byte_word_packer
	import ethernet_bus_pkg::*;
(
	input logic clk_50mhz,
	input logic rst_n,
	byte_lane_if.dst lane,
	input logic host_tx_ready,	// Host accepts one word per cycle while high
	output eth_tx_bus_t host_tx_bus,
	output logic host_tx_overflow	// A word was lost to a full FIFO
);

	localparam int DEPTH = `WORD_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [CW-1:0] FULL_COUNT = CW'(DEPTH);

	logic [31:0] acc_data;	// Word being assembled
	logic [2:0] acc_cnt;	// Bytes held in acc_data, 0 to 4
	logic start_pending;	// Frame opened, its first word not yet buffered
	logic roll;	// Held full word is pushed because another byte follows
	logic [31:0] base_data;
	logic [2:0] base_cnt;
	logic [31:0] next_data;
	logic [2:0] next_cnt;
	logic push;
	logic push_ok;
	logic pop;
	logic fifo_full;
	logic [35:0] push_word;	// Commit, bytes_valid and data
	logic [35:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic out_start;
	logic out_valid;
	logic out_commit;
	logic [2:0] out_bytes;
	logic [31:0] out_data;

	// A full word waits for the next byte or for last, so commit lands on the real final word
	always_comb begin
		roll = lane.valid && !lane.first && acc_cnt == 3'd4;
		base_data = (lane.first || roll) ? 32'd0 : acc_data;
		base_cnt = (lane.first || roll) ? 3'd0 : acc_cnt;
		next_data = base_data;
		next_cnt = base_cnt;
		if (lane.valid) begin
			next_data[base_cnt[1:0]*8 +: 8] = lane.data;	// Byte offset follows arrival order
			next_cnt = base_cnt + 3'd1;
		end
		// The decoder sends last on its own, so roll and last never meet
		push = roll || (lane.last && next_cnt != 3'd0);
		push_word = roll ? {1'b0, 3'd4, acc_data} : {1'b1, next_cnt, next_data};
	end

	assign fifo_full = (count == FULL_COUNT);
	assign pop = host_tx_ready && count != '0;
	assign push_ok = push && (!fifo_full || pop);	// A pop frees the slot in the same cycle

	always_ff @(posedge clk_50mhz) begin
		acc_data <= next_data;
		if (push_ok) begin
			mem[wr_ptr] <= push_word;
		end
		if (pop) begin
			out_data <= mem[rd_ptr][31:0];
			out_bytes <= mem[rd_ptr][34:32];
		end
	end

	always_ff @(posedge clk_50mhz or negedge rst_n) begin
		if (!rst_n) begin
			acc_cnt <= 3'd0;
			start_pending <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_start <= 1'b0;
			out_valid <= 1'b0;
			out_commit <= 1'b0;
			host_tx_overflow <= 1'b0;
		end else begin
			acc_cnt <= lane.last ? 3'd0 : next_cnt;
			out_start <= push_ok && (start_pending || (lane.valid && lane.first));
			if (push_ok || lane.last) begin
				start_pending <= 1'b0;
			end else if (lane.valid && lane.first) begin
				start_pending <= 1'b1;
			end
			host_tx_overflow <= push && !push_ok;	// One pulse per lost word
			out_valid <= pop;
			out_commit <= pop && mem[rd_ptr][35];
			if (push_ok) begin
				wr_ptr <= wr_ptr + AW'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + AW'(1);
			end
			case ({push_ok, pop})
				2'b10: count <= count + CW'(1);
				2'b01: count <= count - CW'(1);
				default: count <= count;	// Both or neither leave the level alone
			endcase
		end
	end

	assign host_tx_bus = '{start: out_start, data_valid: out_valid, bytes_valid: out_bytes,
		data: out_data, commit: out_commit};

	// A word only leaves while the pointers also show the FIFO holding something
	pack_no_empty_pop_a: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
		pop |-> (rd_ptr != wr_ptr) || (count == FULL_COUNT));

	pack_bytes_range_a: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
		out_valid |-> out_bytes inside {[3'd1:3'd4]});

endmodule

`default_nettype wire

/* src/ethernet_bus_consts.svh */
`ifndef ETHERNET_BUS_CONSTS_SVH
`define ETHERNET_BUS_CONSTS_SVH

// Ethernet framing bytes as they appear on the wire, sent LSB dibit first
`define ETH_PREAMBLE_BYTE 8'h55	// Dibit pattern 01 repeated
`define ETH_SFD_BYTE 8'hd5	// Three 01 dibits then 11 closes the preamble

// Preamble bytes ahead of the start-of-frame delimiter
`define ETH_PREAMBLE_LEN 7

// Word FIFO depth in both directions, power of two
`define WORD_FIFO_DEPTH 4

// Minimum clocks between host receive words, one word of dibits at 100 Mbps
`define MIN_WORD_SPACING 16

`endif

/* src/ethernet_bus_pkg.sv */
`default_nettype none

package ethernet_bus_pkg;

	// Frame words from the host toward the RMII side
	typedef struct packed {
		logic start;	// One pulse ahead of the first word of a frame
		logic data_valid;	// Word strobe
		logic [2:0] bytes_valid;	// 1 to 4, fewer than 4 only on the last word
		logic [31:0] data;	// Byte 0 in bits 7:0
		logic commit;	// Frame complete
		logic drop;	// Frame aborted
	} eth_rx_bus_t;

	// Frame words from the RMII side toward the host
	typedef struct packed {
		logic start;	// Pulses when the first word of a frame is buffered
		logic data_valid;	// Word strobe
		logic [2:0] bytes_valid;	// Bytes used in data, from byte 0 upward
		logic [31:0] data;	// Byte 0 in bits 7:0
		logic commit;	// Set together with the final word
	} eth_tx_bus_t;

	// Dibit decoder states
	typedef enum logic [1:0] {
		DEC_IDLE,	// Waiting for tx_en
		DEC_PREAMBLE,	// Hunting for the delimiter
		DEC_DATA	// Assembling frame bytes
	} rx_dec_state_t;

endpackage

`default_nettype wire

/* src/rmii_bridge_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rmii_bridge_top
	import ethernet_bus_pkg::*;
(
	input logic clk_50mhz,
	input logic rst_n,
	input logic host_rx_start,	// Host to MCU frame words
	input logic host_rx_data_valid,
	input logic [2:0] host_rx_bytes_valid,
	input logic [31:0] host_rx_data,
	input logic host_rx_commit,
	input logic host_rx_drop,
	input logic host_tx_ready,	// MCU to host frame words
	output logic host_tx_start,
	output logic host_tx_data_valid,
	output logic [2:0] host_tx_bytes_valid,
	output logic [31:0] host_tx_data,
	output logic host_tx_commit,
	output logic host_tx_overflow,
	output logic rmii_refclk,	// RMII link, bridge on the PHY side
	output logic rmii_rx_en,
	output logic [1:0] rmii_rxd,
	input logic rmii_tx_en,
	input logic [1:0] rmii_txd
);

	eth_rx_bus_t host_rx_bus;
	eth_tx_bus_t host_tx_bus;

	byte_lane_if lane ();	// Decoded bytes from the MCU transmit path

	assign host_rx_bus = '{start: host_rx_start, data_valid: host_rx_data_valid,
		bytes_valid: host_rx_bytes_valid, data: host_rx_data, commit: host_rx_commit,
		drop: host_rx_drop};

	assign host_tx_start = host_tx_bus.start;
	assign host_tx_data_valid = host_tx_bus.data_valid;
	assign host_tx_bytes_valid = host_tx_bus.bytes_valid;
	assign host_tx_data = host_tx_bus.data;
	assign host_tx_commit = host_tx_bus.commit;

	// Outputs change on the rising edge, so the MAC samples mid-bit on the inverted clock
	assign rmii_refclk = ~clk_50mhz;

	rmii_frame_transmitter u_transmitter (
		.clk_50mhz(clk_50mhz),
		.rst_n(rst_n),
		.host_rx_bus(host_rx_bus),
		.rmii_rx_en(rmii_rx_en),
		.rmii_rxd(rmii_rxd)
	);

	rmii_dibit_decoder u_decoder (
		.clk_50mhz(clk_50mhz),
		.rst_n(rst_n),
		.rmii_tx_en(rmii_tx_en),
		.rmii_txd(rmii_txd),
		.lane(lane.src)
	);

	byte_word_packer u_packer (
		.clk_50mhz(clk_50mhz),
		.rst_n(rst_n),
		.lane(lane.dst),
		.host_tx_ready(host_tx_ready),
		.host_tx_bus(host_tx_bus),
		.host_tx_overflow(host_tx_overflow)
	);

endmodule

`default_nettype wire

/* src/rmii_dibit_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ethernet_bus_consts.svh"

module rmii_dibit_decoder
	import ethernet_bus_pkg::*;
(
	input logic clk_50mhz,
	input logic rst_n,
	input logic rmii_tx_en,	// Carrier from the MAC
	input logic [1:0] rmii_txd,	// Dibits from the MAC, LSB dibit first
	byte_lane_if.src lane
);

	rx_dec_state_t state;
	logic [7:0] shift_reg;	// Last four dibits, newest in bits 7:6
	logic [7:0] window;	// Shift register including this cycle's dibit
	logic [1:0] dibit_cnt;	// Dibit position within the current data byte
	logic pre_seen;	// At least one whole preamble byte went by
	logic first_pending;	// Next completed byte opens the frame

	// Incoming dibit lands on top so that four shifts give a byte in wire order
	assign window = {rmii_txd, shift_reg[7:2]};

	always_ff @(posedge clk_50mhz) begin
		shift_reg <= window;	// Runs freely, state decides what the bits mean
	end

	always_ff @(posedge clk_50mhz or negedge rst_n) begin
		if (!rst_n) begin
			state <= DEC_IDLE;
			dibit_cnt <= 2'd0;
			pre_seen <= 1'b0;
			first_pending <= 1'b0;
			lane.valid <= 1'b0;
			lane.first <= 1'b0;
			lane.last <= 1'b0;
		end else begin
			lane.valid <= 1'b0;	// Strobes default low
			lane.first <= 1'b0;
			lane.last <= 1'b0;
			case (state)
				DEC_IDLE: begin
					pre_seen <= 1'b0;
					if (rmii_tx_en) begin
						state <= DEC_PREAMBLE;	// First dibit is already in the window
					end
				end
				DEC_PREAMBLE: begin
					if (!rmii_tx_en) begin
						state <= DEC_IDLE;	// Carrier lost before a delimiter, nothing to report
					end else if (window == `ETH_PREAMBLE_BYTE) begin
						pre_seen <= 1'b1;
					end else if (pre_seen && window == `ETH_SFD_BYTE) begin
						state <= DEC_DATA;	// Byte alignment is fixed from here on
						dibit_cnt <= 2'd0;
						first_pending <= 1'b1;
					end
				end
				DEC_DATA: begin
					if (!rmii_tx_en) begin
						state <= DEC_IDLE;	// Any partial byte is simply dropped
						lane.last <= 1'b1;
					end else begin
						dibit_cnt <= dibit_cnt + 2'd1;
						if (dibit_cnt == 2'd3) begin
							lane.valid <= 1'b1;	// Byte goes out the cycle after its fourth dibit
							lane.first <= first_pending;
							first_pending <= 1'b0;
						end
					end
				end
				default: begin
					state <= DEC_IDLE;
				end
			endcase
		end
	end

	// Completed byte is captured together with its fourth dibit
	always_ff @(posedge clk_50mhz) begin
		if (state == DEC_DATA && rmii_tx_en && dibit_cnt == 2'd3) begin
			lane.data <= window;
		end
	end

	// Idle means quiet on the lane, apart from the end marker that closes a frame
	dec_idle_quiet_a: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
		(state == DEC_IDLE) |-> !lane.valid && (!lane.last || $past(state) == DEC_DATA));

endmodule

`default_nettype wire

/* src/rmii_frame_transmitter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ethernet_bus_consts.svh"

module rmii_frame_transmitter
	import ethernet_bus_pkg::*;
(
	input logic clk_50mhz,
	input logic rst_n,
	input eth_rx_bus_t host_rx_bus,
	output logic rmii_rx_en,	// Carrier toward the MAC
	output logic [1:0] rmii_rxd	// Dibits toward the MAC, LSB dibit first
);

	localparam int DEPTH = `WORD_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [CW-1:0] FULL_COUNT = CW'(DEPTH);
	localparam int PRE_DIBITS = (`ETH_PREAMBLE_LEN + 1) * 4;	// Preamble plus delimiter
	localparam int PW = $clog2(PRE_DIBITS);

	logic [34:0] mem [DEPTH];	// bytes_valid over data
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [34:0] head;	// Oldest buffered word
	logic push;
	logic pop;
	logic in_preamble;
	logic [PW-1:0] pre_cnt;	// Preamble dibits already sent
	logic commit_pending;	// Host has closed the frame
	logic [29:0] shift_data;	// Dibits of the current word still to go
	logic [4:0] dibits_left;	// Count of those dibits, up to 15

	// Dibit idx of the preamble, seven 55 bytes and then the delimiter
	function automatic logic [1:0] pre_dibit(input logic [PW-1:0] idx);
		logic [7:0] pre_byte;
		pre_byte = (idx < PW'(`ETH_PREAMBLE_LEN * 4)) ? `ETH_PREAMBLE_BYTE : `ETH_SFD_BYTE;
		return pre_byte[idx[1:0]*2 +: 2];
	endfunction

	assign head = mem[rd_ptr];
	assign push = host_rx_bus.data_valid && !host_rx_bus.drop;
	// Next word is fetched the cycle the previous one runs dry, so dibits go out back to back
	assign pop = rmii_rx_en && !in_preamble && dibits_left == 5'd0 && count != '0
		&& !host_rx_bus.drop;

	always_ff @(posedge clk_50mhz) begin
		if (push) begin
			mem[wr_ptr] <= {host_rx_bus.bytes_valid, host_rx_bus.data};
		end
		if (pop) begin
			shift_data <= head[31:2];	// Dibit 0 leaves right away
		end else if (dibits_left != 5'd0) begin
			shift_data <= {2'b00, shift_data[29:2]};
		end
	end

	always_ff @(posedge clk_50mhz or negedge rst_n) begin
		if (!rst_n) begin
			rmii_rx_en <= 1'b0;
			rmii_rxd <= 2'b00;
			in_preamble <= 1'b0;
			pre_cnt <= '0;
			commit_pending <= 1'b0;
			dibits_left <= 5'd0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (host_rx_bus.drop) begin
			rmii_rx_en <= 1'b0;	// Abort cuts the carrier and throws away the buffered words
			rmii_rxd <= 2'b00;
			in_preamble <= 1'b0;
			commit_pending <= 1'b0;
			dibits_left <= 5'd0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (host_rx_bus.commit) begin
				commit_pending <= 1'b1;
			end
			if (host_rx_bus.start && !rmii_rx_en) begin
				rmii_rx_en <= 1'b1;
				rmii_rxd <= pre_dibit('0);
				in_preamble <= 1'b1;
				pre_cnt <= PW'(1);
			end else if (in_preamble) begin
				rmii_rxd <= pre_dibit(pre_cnt);
				pre_cnt <= pre_cnt + PW'(1);
				if (pre_cnt == PW'(PRE_DIBITS - 1)) begin
					in_preamble <= 1'b0;	// Delimiter's last dibit is on the pins now
				end
			end else if (dibits_left != 5'd0) begin
				rmii_rxd <= shift_data[1:0];
				dibits_left <= dibits_left - 5'd1;
			end else if (pop) begin
				rmii_rxd <= head[1:0];
				dibits_left <= {head[34:32], 2'b00} - 5'd1;	// Four dibits per byte, one sent
			end else if (rmii_rx_en && commit_pending) begin
				rmii_rx_en <= 1'b0;	// Falls right after the final dibit
				rmii_rxd <= 2'b00;
				commit_pending <= 1'b0;
			end
			// With the host pacing held, the carrier never waits here for a late word
			if (push) begin
				wr_ptr <= wr_ptr + AW'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + AW'(1);
			end
			case ({push, pop})
				2'b10: count <= count + CW'(1);
				2'b01: count <= count - CW'(1);
				default: count <= count;
			endcase
		end
	end

	// Host words must be spaced out, the FIFO relies on it
	tx_word_spacing_a: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
		host_rx_bus.data_valid |=> !host_rx_bus.data_valid [* `MIN_WORD_SPACING - 1]);

	tx_fifo_no_overflow_a: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
		push |-> (count != FULL_COUNT) || pop);

endmodule

`default_nettype wire
